// File: design/ex_pkg.sv
`default_nettype none

package ex_pkg;

    // ***********************************************************
    // widths
    // ***********************************************************

    // rv64 datapath
    localparam int unsigned XLEN = 64;
    // instruction word
    localparam int unsigned ILEN = 32;
    // word ops produce 32-bit results
    localparam int unsigned WORD_W = 32;
    // register index
    localparam int unsigned REG_AW = 5;

    // ***********************************************************
    // encodings
    // ***********************************************************

    // executed operation, already decoded upstream
    typedef enum logic [4:0] {
        OP_NONE,
        OP_ALU,
        OP_ALU_W,
        OP_ALU_WHI,
        OP_LUI,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_LWU,
        OP_LD,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SD
    } ex_op_e;

    // alu function, code 5 unused
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10
    } alu_mode_e;

    // ***********************************************************
    // stage payloads
    // ***********************************************************

    // one issued instruction, operands already prepared
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [ILEN-1:0]   inst;
        ex_op_e            op;
        alu_mode_e         alu_mode;
        logic [XLEN-1:0]   op_a;
        logic [XLEN-1:0]   op_b;
        logic [XLEN-1:0]   src2;
        logic [REG_AW-1:0] rd;
    } ex_issue_t;

    // next-pc redirect to fetch
    typedef struct packed {
        logic            pc_update;
        logic [XLEN-1:0] dnpc;
    } ex_redirect_t;

    // register write-back
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [ILEN-1:0]   inst;
        logic              wen;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   value;
    } ex_wb_t;

endpackage

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // data memory port widths
    localparam int unsigned DMEM_AW = 64;
    localparam int unsigned DMEM_DW = 64;
    // one strobe bit per byte
    localparam int unsigned DMEM_MW = DMEM_DW / 8;

    // access width of a load or store
    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_HALF,
        SZ_WORD,
        SZ_DOUBLE
    } access_size_e;

    // combinational request, read data comes back same cycle
    // write happens when wmask is nonzero
    typedef struct packed {
        logic               ren;
        logic [DMEM_AW-1:0] raddr;
        logic [DMEM_MW-1:0] wmask;
        logic [DMEM_AW-1:0] waddr;
        logic [DMEM_DW-1:0] wdata;
    } dmem_req_t;

endpackage

`default_nettype wire

// File: design/ex_alu.sv
`timescale 1ns/100ps
`default_nettype none

module ex_alu (
    input  ex_pkg::alu_mode_e           mode,
    input  logic [ex_pkg::XLEN-1:0]     op_a,
    input  logic [ex_pkg::XLEN-1:0]     op_b,
    output logic [ex_pkg::XLEN-1:0]     result
);

    import ex_pkg::*;

    // rv64 shift amount, word shifts arrive pre-masked
    logic [5:0] shamt;
    // compare results, 0 or 1
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = op_b[5:0];
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (mode)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            // set-less-than, zero extended flag
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            // logic ops
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            // shifts
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            // unused codes give zero
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module ex_branch_unit (
    input  ex_pkg::ex_op_e              op,
    input  logic [ex_pkg::XLEN-1:0]     pc,
    input  logic [ex_pkg::ILEN-1:7]     inst,
    input  logic [ex_pkg::XLEN-1:0]     op_a,
    input  logic [ex_pkg::XLEN-1:0]     op_b,
    input  logic [ex_pkg::XLEN-1:0]     alu_result,
    output ex_pkg::ex_redirect_t        redirect
);

    import ex_pkg::*;

    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] snpc;
    logic            taken;

    // b-type offset, bit 0 always zero
    assign imm_b = {{(XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign snpc  = pc + XLEN'(4);

    // condition of each branch
    always_comb begin
        case (op)
            OP_BEQ:  taken = op_a == op_b;
            OP_BNE:  taken = op_a != op_b;
            OP_BLT:  taken = $signed(op_a) < $signed(op_b);
            OP_BGE:  taken = $signed(op_a) >= $signed(op_b);
            OP_BLTU: taken = op_a < op_b;
            OP_BGEU: taken = op_a >= op_b;
            default: taken = 1'b0;
        endcase
    end

    // next pc, sequential unless jump or branch
    always_comb begin
        redirect.pc_update = 1'b0;
        redirect.dnpc      = snpc;
        case (op)
            OP_JAL: begin
                redirect.pc_update = 1'b1;
                redirect.dnpc      = alu_result;
            end
            // jalr target drops bit 0
            OP_JALR: begin
                redirect.pc_update = 1'b1;
                redirect.dnpc      = {alu_result[XLEN-1:1], 1'b0};
            end
            // not-taken still redirects, to pc+4
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                redirect.pc_update = 1'b1;
                redirect.dnpc      = taken ? pc + imm_b : snpc;
            end
            default: begin
                redirect.pc_update = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_lsu_align.sv
`timescale 1ns/100ps
`default_nettype none

module ex_lsu_align (
    input  ex_pkg::ex_op_e                op,
    input  logic [ex_pkg::XLEN-1:0]       alu_result,
    input  logic [ex_pkg::XLEN-1:0]       src2,
    input  logic [mem_pkg::DMEM_DW-1:0]   dmem_rdata,
    output mem_pkg::dmem_req_t            dmem_req,
    output logic [ex_pkg::XLEN-1:0]       load_value
);

    import ex_pkg::*;
    import mem_pkg::*;

    access_size_e       size;
    logic               is_load;
    logic               is_store;
    logic               load_signed;
    // byte lane inside the doubleword
    logic [2:0]         lane;
    logic [DMEM_MW-1:0] base_mask;
    logic [DMEM_MW-1:0] lane_mask;
    // lane mask widened to bits
    logic [DMEM_DW-1:0] bit_mask;
    logic [DMEM_DW-1:0] rdata_lane;

    // ***********************************************************
    // access decode
    // ***********************************************************

    assign is_load     = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD};
    assign is_store    = op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    assign load_signed = op inside {OP_LB, OP_LH, OP_LW};

    always_comb begin
        case (op)
            OP_LB, OP_LBU, OP_SB: size = SZ_BYTE;
            OP_LH, OP_LHU, OP_SH: size = SZ_HALF;
            OP_LW, OP_LWU, OP_SW: size = SZ_WORD;
            default:              size = SZ_DOUBLE;
        endcase
    end

    // lane and mask per size
    // words sit in the half picked by bit 2, doubles at lane 0
    always_comb begin
        case (size)
            SZ_BYTE: begin
                lane      = alu_result[2:0];
                base_mask = 8'h01;
            end
            SZ_HALF: begin
                lane      = alu_result[2:0];
                base_mask = 8'h03;
            end
            SZ_WORD: begin
                lane      = {alu_result[2], 2'b00};
                base_mask = 8'h0f;
            end
            default: begin
                lane      = 3'd0;
                base_mask = 8'hff;
            end
        endcase
    end

    assign lane_mask = base_mask << lane;

    always_comb begin
        for (int i = 0; i < DMEM_MW; i++) begin
            bit_mask[i*8 +: 8] = {8{lane_mask[i]}};
        end
    end

    // ***********************************************************
    // memory request
    // ***********************************************************

    // addresses stay zero unless a load or store is executing
    assign dmem_req.ren   = is_load;
    assign dmem_req.raddr = is_load ? alu_result : '0;
    assign dmem_req.waddr = is_store ? alu_result : '0;
    assign dmem_req.wmask = is_store ? lane_mask : '0;
    // store data moved into its lane, other lanes zero
    assign dmem_req.wdata = is_store ? ((src2 << {lane, 3'b000}) & bit_mask) : '0;

    // ***********************************************************
    // load extraction
    // ***********************************************************

    // selected bytes brought down to bit 0
    assign rdata_lane = dmem_rdata >> {lane, 3'b000};

    always_comb begin
        load_value = '0;
        if (is_load) begin
            case (size)
                SZ_BYTE: load_value = {{(XLEN-8){load_signed & rdata_lane[7]}},
                                       rdata_lane[7:0]};
                SZ_HALF: load_value = {{(XLEN-16){load_signed & rdata_lane[15]}},
                                       rdata_lane[15:0]};
                SZ_WORD: load_value = {{(XLEN-32){load_signed & rdata_lane[31]}},
                                       rdata_lane[31:0]};
                default: load_value = rdata_lane;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/ex_writeback_sel.sv
`timescale 1ns/100ps
`default_nettype none

module ex_writeback_sel (
    input  ex_pkg::ex_op_e              op,
    input  logic [ex_pkg::XLEN-1:0]     pc,
    input  logic [ex_pkg::XLEN-1:0]     op_a,
    input  logic [ex_pkg::XLEN-1:0]     alu_result,
    input  logic [ex_pkg::XLEN-1:0]     load_value,
    output logic                        wen,
    output logic [ex_pkg::XLEN-1:0]     value
);

    import ex_pkg::*;

    // link address for jumps
    logic [XLEN-1:0]   snpc;
    // word results, sign extended
    logic [XLEN-1:0]   word_lo;
    logic [XLEN-1:0]   word_hi;

    assign snpc = pc + XLEN'(4);

    // low half for normal word ops
    assign word_lo = {{(XLEN-WORD_W){alu_result[WORD_W-1]}}, alu_result[WORD_W-1:0]};
    // high half for word shifts done in the upper 32 bits
    assign word_hi = {{(XLEN-WORD_W){alu_result[XLEN-1]}}, alu_result[XLEN-1:WORD_W]};

    // x0 filtering left to the register file
    always_comb begin
        wen   = 1'b1;
        value = '0;
        case (op)
            OP_ALU:           value = alu_result;
            OP_ALU_W:         value = word_lo;
            OP_ALU_WHI:       value = word_hi;
            // upper immediate prepared in op_a
            OP_LUI:           value = op_a;
            OP_JAL, OP_JALR:  value = snpc;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD: begin
                value = load_value;
            end
            // branches, stores, idle
            default: begin
                wen = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  ex_pkg::ex_issue_t             issue,
    input  logic [mem_pkg::DMEM_DW-1:0]   dmem_rdata,
    output mem_pkg::dmem_req_t            dmem_req,
    output ex_pkg::ex_redirect_t          redirect,
    output ex_pkg::ex_wb_t                wb
);

    import ex_pkg::*;

    // ***********************************************************
    // pipeline register
    // ***********************************************************

    ex_issue_t       ex_q;
    // operation seen by the units, idle when not valid
    ex_op_e          op;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_value;
    logic            wb_wen;
    logic [XLEN-1:0] wb_value;

    // captured every edge, no back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= '0;
        end else begin
            ex_q <= issue;
        end
    end

    // the only validity check in the stage
    assign op = ex_q.valid ? ex_q.op : OP_NONE;

    // ***********************************************************
    // execute units
    // ***********************************************************

    ex_alu u_alu (
        .mode   (ex_q.alu_mode),
        .op_a   (ex_q.op_a),
        .op_b   (ex_q.op_b),
        .result (alu_result)
    );

    // branch offset only needs inst[31:7]
    ex_branch_unit u_branch (
        .op         (op),
        .pc         (ex_q.pc),
        .inst       (ex_q.inst[ILEN-1:7]),
        .op_a       (ex_q.op_a),
        .op_b       (ex_q.op_b),
        .alu_result (alu_result),
        .redirect   (redirect)
    );

    ex_lsu_align u_lsu (
        .op         (op),
        .alu_result (alu_result),
        .src2       (ex_q.src2),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .load_value (load_value)
    );

    ex_writeback_sel u_wb_sel (
        .op         (op),
        .pc         (ex_q.pc),
        .op_a       (ex_q.op_a),
        .alu_result (alu_result),
        .load_value (load_value),
        .wen        (wb_wen),
        .value      (wb_value)
    );

    // write-back bundle
    always_comb begin
        wb.valid = ex_q.valid;
        wb.pc    = ex_q.pc;
        wb.inst  = ex_q.inst;
        wb.wen   = wb_wen;
        wb.rd    = ex_q.rd;
        wb.value = wb_value;
    end

endmodule

`default_nettype wire

// File: verification/tb_ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ex_stage;

    import ex_pkg::*;
    import mem_pkg::*;

    // tests take about 150 cycles, limit is roughly ten times that
    localparam int unsigned TEST_CYCLES = 200;
    localparam int unsigned MAX_CYCLES  = 10 * TEST_CYCLES;

    logic         clk = 1'b0;
    logic         rst;
    ex_issue_t    issue;
    logic [63:0]  dmem_rdata;
    dmem_req_t    dmem_req;
    ex_redirect_t redirect;
    ex_wb_t       wb;

    // model memory, 64 doublewords
    logic [63:0]  mem [64];
    // byte image the model is expected to hold
    logic [7:0]   shadow [512];
    int unsigned  cycles;

    always #5 clk = ~clk;

    ex_stage dut (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .redirect   (redirect),
        .wb         (wb)
    );

    // ***********************************************************
    // reference rules and memory model
    // ***********************************************************

    // pattern from the whole byte address
    function automatic logic [7:0] fill_byte(input logic [8:0] a);
        return 8'(a * 9'd37) ^ 8'(a >> 3) ^ 8'h5a;
    endfunction

    function automatic logic [63:0] fill_word(input logic [5:0] w);
        logic [63:0] word;
        word = '0;
        for (logic [3:0] b = 4'd0; b < 4'd8; b++) begin
            word = word | (64'(fill_byte({w, b[2:0]})) << (8 * b));
        end
        return word;
    endfunction

    // byte strobes widened to bit strobes
    function automatic logic [63:0] lane_bits(input logic [7:0] m);
        logic [63:0] bits;
        logic [7:0]  rest;
        bits = '0;
        rest = m;
        for (int b = 0; b < 8; b++) begin
            if (rest[0]) begin
                bits = bits | (64'hff << (8 * b));
            end
            rest = rest >> 1;
        end
        return bits;
    endfunction

    // reads answer at once, writes land on the rising edge
    assign dmem_rdata = mem[dmem_req.raddr[8:3]];

    always @(posedge clk) begin
        if (rst) begin
            for (logic [6:0] w = 7'd0; w < 7'd64; w++) begin
                mem[w[5:0]] <= fill_word(w[5:0]);
            end
        end else if (dmem_req.wmask != 8'd0) begin
            mem[dmem_req.waddr[8:3]] <= (mem[dmem_req.waddr[8:3]] & ~lane_bits(dmem_req.wmask))
                                      | (dmem_req.wdata & lane_bits(dmem_req.wmask));
        end
    end

    function automatic logic [63:0] ref_alu(input alu_mode_e mode, input logic [63:0] a,
                                            input logic [63:0] b);
        logic [5:0] sh;
        logic       less;
        sh   = b[5:0];
        // signed order flips when the signs differ
        less = (a[63] != b[63]) ? a[63] : (a < b);
        case (mode)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 64'd1;
            ALU_SLT:  return {63'd0, less};
            ALU_SLTU: return {63'd0, a < b};
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            // vacated top bits take the sign
            ALU_SRA:  return (a >> sh) | ({64{a[63]}} & ~(~64'd0 >> sh));
            default:  return 64'd0;
        endcase
    endfunction

    function automatic logic branch_taken(input ex_op_e op, input logic [63:0] a,
                                          input logic [63:0] b);
        logic lt_u;
        logic lt_s;
        lt_u = a < b;
        lt_s = (a[63] != b[63]) ? a[63] : lt_u;
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return lt_s;
            OP_BGE:  return !lt_s;
            OP_BLTU: return lt_u;
            OP_BGEU: return !lt_u;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] sign_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic int size_bytes(input access_size_e s);
        case (s)
            SZ_BYTE: return 1;
            SZ_HALF: return 2;
            SZ_WORD: return 4;
            default: return 8;
        endcase
    endfunction

    // valid issue, random pc, inst, src2 and rd
    function automatic ex_issue_t make_issue(input ex_op_e op, input alu_mode_e mode,
                                             input logic [63:0] a, input logic [63:0] b);
        ex_issue_t i;
        i.valid    = 1'b1;
        i.pc       = {32'd0, 32'h8000_0000 | ($urandom & 32'h00ff_fffc)};
        i.inst     = $urandom;
        i.op       = op;
        i.alu_mode = mode;
        i.op_a     = a;
        i.op_b     = b;
        i.src2     = {$urandom, $urandom};
        i.rd       = 5'($urandom);
        return i;
    endfunction

    function automatic ex_wb_t expect_wb(input ex_issue_t i, input logic wen,
                                         input logic [63:0] value);
        ex_wb_t w;
        w.valid = 1'b1;
        w.pc    = i.pc;
        w.inst  = i.inst;
        w.wen   = wen;
        w.rd    = i.rd;
        w.value = value;
        return w;
    endfunction

    // ***********************************************************
    // drive and compare
    // ***********************************************************

    task automatic abort_run(input string why);
        $display("Testbench failed");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            abort_run("wrong value on a DUT output");
        end
    endtask

    // issue on the falling edge, result is checked one cycle later
    task automatic execute(input ex_issue_t i);
        issue = i;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic check_wb(input ex_wb_t exp);
        compare_field("wb.valid", 64'(wb.valid), 64'(exp.valid));
        compare_field("wb.pc", wb.pc, exp.pc);
        compare_field("wb.inst", 64'(wb.inst), 64'(exp.inst));
        compare_field("wb.rd", 64'(wb.rd), 64'(exp.rd));
        compare_field("wb.wen", 64'(wb.wen), 64'(exp.wen));
        // value only matters when written
        if (exp.wen) begin
            compare_field("wb.value", wb.value, exp.value);
        end
    endtask

    task automatic check_redirect(input ex_redirect_t exp);
        compare_field("redirect.pc_update", 64'(redirect.pc_update), 64'(exp.pc_update));
        if (exp.pc_update) begin
            compare_field("redirect.dnpc", redirect.dnpc, exp.dnpc);
        end
    endtask

    task automatic check_dmem(input dmem_req_t exp);
        compare_field("dmem_req.ren", 64'(dmem_req.ren), 64'(exp.ren));
        compare_field("dmem_req.wmask", 64'(dmem_req.wmask), 64'(exp.wmask));
        if (exp.ren) begin
            compare_field("dmem_req.raddr", dmem_req.raddr, exp.raddr);
        end
        if (exp.wmask != 8'd0) begin
            compare_field("dmem_req.waddr", dmem_req.waddr, exp.waddr);
            compare_field("dmem_req.wdata", dmem_req.wdata, exp.wdata);
        end
    endtask

    task automatic check_memory();
        logic [63:0] exp;
        for (logic [6:0] w = 7'd0; w < 7'd64; w++) begin
            exp = '0;
            for (logic [3:0] b = 4'd0; b < 4'd8; b++) begin
                exp = exp | (64'(shadow[{w[5:0], b[2:0]}]) << (8 * b));
            end
            compare_field($sformatf("mem[%0d]", w), mem[w[5:0]], exp);
        end
    endtask

    // ***********************************************************
    // directed tests
    // ***********************************************************

    task automatic reset_idle_outputs();
        ex_op_e    ops [3] = '{OP_JAL, OP_LD, OP_SD};
        ex_issue_t i;
        ex_wb_t    w;
        // straight out of reset, then one idle issue
        check_wb('0);
        check_redirect('0);
        check_dmem('0);
        execute('0);
        check_wb('0);
        check_redirect('0);
        check_dmem('0);
        // invalid issues with a live op must stay silent
        foreach (ops[k]) begin
            i = make_issue(ops[k], ALU_ADD, {$urandom, $urandom}, 64'd0);
            i.valid = 1'b0;
            execute(i);
            w       = expect_wb(i, 1'b0, 64'd0);
            w.valid = 1'b0;
            check_wb(w);
            check_redirect('0);
            check_dmem('0);
        end
    endtask

    task automatic alu_modes();
        alu_mode_e   modes [10] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
                                    ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
        ex_issue_t   i;
        alu_mode_e   mode;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        foreach (modes[k]) begin
            for (int n = 0; n < 4; n++) begin
                a = {$urandom, $urandom};
                b = {$urandom, $urandom};
                // equal operands once per mode
                if (n == 3) begin
                    b = a;
                end
                i = make_issue(OP_ALU, modes[k], a, b);
                execute(i);
                check_wb(expect_wb(i, 1'b1, ref_alu(modes[k], a, b)));
                check_redirect('0);
                check_dmem('0);
            end
        end
        // word forms, low half from an add, high half from a shift
        for (int n = 0; n < 4; n++) begin
            a = {$urandom, $urandom};
            b = {$urandom, $urandom};
            i = make_issue(OP_ALU_W, ALU_ADD, a, b);
            execute(i);
            r = a + b;
            check_wb(expect_wb(i, 1'b1, sign_word(r[31:0])));
            mode = (n % 2 == 1) ? ALU_SLL : ALU_SRA;
            i = make_issue(OP_ALU_WHI, mode, a, b);
            execute(i);
            r = ref_alu(mode, a, b);
            check_wb(expect_wb(i, 1'b1, sign_word(r[63:32])));
            check_dmem('0);
        end
    endtask

    task automatic jumps_and_lui();
        ex_issue_t    i;
        ex_redirect_t exp_rd;
        logic [63:0]  a;
        logic [63:0]  b;
        logic [31:0]  off;
        // lui value arrives ready in op_a
        a = {$urandom, $urandom} & ~64'hfff;
        // random op_b keeps the alu sum apart from op_a
        i = make_issue(OP_LUI, ALU_ADD, a, {$urandom, $urandom});
        execute(i);
        check_wb(expect_wb(i, 1'b1, a));
        check_redirect('0);
        check_dmem('0);
        // jal, pc plus an even offset
        off = $urandom;
        b = {{43{off[20]}}, off[20:1], 1'b0};
        i = make_issue(OP_JAL, ALU_ADD, 64'd0, b);
        i.op_a = i.pc;
        execute(i);
        check_wb(expect_wb(i, 1'b1, i.pc + 64'd4));
        exp_rd.pc_update = 1'b1;
        exp_rd.dnpc      = i.pc + b;
        check_redirect(exp_rd);
        check_dmem('0);
        // jalr with an odd sum, bit 0 must drop
        a = {$urandom, $urandom} & ~64'd1;
        b = 64'($signed(off[11:0])) | 64'd1;
        i = make_issue(OP_JALR, ALU_ADD, a, b);
        execute(i);
        check_wb(expect_wb(i, 1'b1, i.pc + 64'd4));
        exp_rd.dnpc = (a + b) & ~64'd1;
        check_redirect(exp_rd);
        check_dmem('0);
    endtask

    task automatic branch_conditions();
        ex_op_e       ops [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        ex_issue_t    i;
        ex_redirect_t exp_rd;
        logic [63:0]  neg;
        logic [63:0]  pos;
        logic [63:0]  a;
        logic [63:0]  b;
        logic [12:0]  off;
        foreach (ops[k]) begin
            // three pairs give every branch a taken and a not-taken case
            for (int n = 0; n < 3; n++) begin
                neg = {1'b1, 31'($urandom), $urandom};
                pos = {1'b0, 31'($urandom), $urandom};
                case (n)
                    0: begin
                        a = neg;
                        b = pos;
                    end
                    1: begin
                        a = pos;
                        b = neg;
                    end
                    default: begin
                        a = pos;
                        b = pos;
                    end
                endcase
                off = {12'($urandom), 1'b0};
                i = make_issue(ops[k], ALU_ADD, a, b);
                // b-type immediate fields
                i.inst[31]    = off[12];
                i.inst[7]     = off[11];
                i.inst[30:25] = off[10:5];
                i.inst[11:8]  = off[4:1];
                execute(i);
                exp_rd.pc_update = 1'b1;
                if (branch_taken(ops[k], a, b)) begin
                    exp_rd.dnpc = i.pc + {{51{off[12]}}, off};
                end else begin
                    exp_rd.dnpc = i.pc + 64'd4;
                end
                check_wb(expect_wb(i, 1'b0, 64'd0));
                check_redirect(exp_rd);
                check_dmem('0);
            end
        end
    endtask

    task automatic store_lanes();
        ex_op_e       ops [4]   = '{OP_SB, OP_SH, OP_SW, OP_SD};
        access_size_e sizes [4] = '{SZ_BYTE, SZ_HALF, SZ_WORD, SZ_DOUBLE};
        ex_issue_t    i;
        dmem_req_t    d;
        logic [8:0]   base;
        logic [8:0]   addr;
        int           nbytes;
        // one doubleword per size
        foreach (ops[k]) begin
            nbytes = size_bytes(sizes[k]);
            base   = 9'h080 + 9'(8 * k);
            for (int off = 0; off < 8; off += nbytes) begin
                addr = base + 9'(off);
                i = make_issue(ops[k], ALU_ADD, 64'(base), 64'(off));
                execute(i);
                // src2 moves up to the lane of its address
                d       = '0;
                d.waddr = 64'(addr);
                d.wmask = 8'(((16'd1 << nbytes) - 16'd1) << off);
                d.wdata = (i.src2 << (8 * off))
                        & (((64'd1 << (8 * nbytes)) - 64'd1) << (8 * off));
                for (int j = 0; j < nbytes; j++) begin
                    shadow[addr + 9'(j)] = 8'(i.src2 >> (8 * j));
                end
                check_wb(expect_wb(i, 1'b0, 64'd0));
                check_redirect('0);
                check_dmem(d);
            end
        end
        // last write lands on this edge
        execute('0);
        check_memory();
    endtask

    task automatic load_extraction();
        ex_op_e       ops [7]   = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU, OP_LD};
        access_size_e sizes [7] = '{SZ_BYTE, SZ_HALF, SZ_WORD, SZ_BYTE,
                                    SZ_HALF, SZ_WORD, SZ_DOUBLE};
        logic         sext [7]  = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
        // one stored doubleword, one still at its fill pattern
        logic [8:0]   bases [2] = '{9'h088, 9'h1f0};
        ex_issue_t    i;
        dmem_req_t    d;
        logic [8:0]   addr;
        logic [7:0]   top;
        logic [63:0]  v;
        int           nbytes;
        // issued back to back, each result one cycle after its issue
        foreach (bases[m]) begin
            foreach (ops[k]) begin
                nbytes = size_bytes(sizes[k]);
                for (int off = 0; off < 8; off += nbytes) begin
                    addr = bases[m] + 9'(off);
                    i = make_issue(ops[k], ALU_ADD, 64'(bases[m]), 64'(off));
                    execute(i);
                    v = '0;
                    for (int j = nbytes - 1; j >= 0; j--) begin
                        v = (v << 8) | 64'(shadow[addr + 9'(j)]);
                    end
                    // extend from the top byte loaded
                    top = shadow[addr + 9'(nbytes - 1)];
                    if (sext[k] && top[7]) begin
                        v = v | (~64'd0 << (8 * nbytes));
                    end
                    d       = '0;
                    d.ren   = 1'b1;
                    d.raddr = 64'(addr);
                    check_wb(expect_wb(i, 1'b1, v));
                    check_redirect('0);
                    check_dmem(d);
                end
            end
        end
    endtask

    // ***********************************************************
    // run control
    // ***********************************************************

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        abort_run("timeout, the tests did not finish within the cycle limit");
    end

    initial begin
        void'($urandom(32'hcc5c73aa));
        rst   = 1'b1;
        issue = '0;
        for (logic [9:0] a = 10'd0; a < 10'd512; a++) begin
            shadow[a[8:0]] = fill_byte(a[8:0]);
        end
        // three edges of reset, released on a falling edge
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_idle_outputs();
        alu_modes();
        jumps_and_lui();
        branch_conditions();
        store_lanes();
        load_extraction();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: ex_stage.f
design/ex_pkg.sv
design/mem_pkg.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_lsu_align.sv
design/ex_writeback_sel.sv
design/ex_stage.sv
verification/tb_ex_stage.sv

// File: Makefile
TOP := tb_ex_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module ex_stage \
		design/ex_pkg.sv design/mem_pkg.sv design/ex_alu.sv design/ex_branch_unit.sv \
		design/ex_lsu_align.sv design/ex_writeback_sel.sv design/ex_stage.sv

sim:
	verilator --binary --timing --top-module $(TOP) -f ex_stage.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
